// File: filelist.f
source/busPkg.sv
source/ciPkg.sv
source/resetSequencer.sv
source/busArbiter.sv
source/sharedRam.sv
source/dmaEngine.sv
source/pixelOps.sv
source/profileCounters.sv
source/fabricTop.sv
testbench/busArbiter_sva.sv
testbench/fabricTb.sv

// File: source/busArbiter.sv
// Bus arbiter, fixed-priority grants, idle flag and timeout bus error
module busArbiter (
  input  logic                           s_systemClock,
  input  logic                           reset,
  input  logic [busPkg::masterCount-1:0] busRequests,
  output logic [busPkg::masterCount-1:0] busGrants,
  input  busPkg::busRequest_t            sharedRequest,
  input  busPkg::busResponse_t           sharedResponse,
  output busPkg::busResponse_t           arbiterResponse,
  output logic                           busIdle
);

  logic [busPkg::masterCount-1:0]                   lowestRequest;
  logic                                             timeoutActive;
  logic [$clog2(busPkg::busTimeoutCycles + 1)-1:0]  timeoutCount;
  logic                                             timeoutExpired;

  // Isolate the lowest set request bit
  assign lowestRequest = busRequests & (~busRequests + 1'b1);
  assign busIdle = (busGrants == '0);

  // New grant only when the bus is free, held while its request stays up
  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      busGrants <= '0;
    end else if (busGrants == '0) begin
      busGrants <= lowestRequest;
    end else begin
      busGrants <= busGrants & busRequests;
    end
  end

  assign timeoutExpired = timeoutActive &&
                          (timeoutCount == busPkg::busTimeoutCycles);

  // Count equals the number of cycles since begin
  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      timeoutActive <= 1'b0;
      timeoutCount <= '0;
    end else if (sharedRequest.beginTransaction) begin
      timeoutActive <= 1'b1;
      timeoutCount <= 1;
    end else if (sharedResponse.endTransaction || timeoutExpired) begin
      timeoutActive <= 1'b0;
      timeoutCount <= '0;
    end else if (timeoutActive) begin
      timeoutCount <= timeoutCount + 1'b1;
    end
  end

  // Nobody answered, close the transaction with an error
  assign arbiterResponse = '{
    endTransaction: timeoutExpired,
    dataValid: 1'b0,
    busError: timeoutExpired,
    readData: 32'd0
  };

endmodule

// File: source/busPkg.sv
// Shared bus package with request and response structs, address map and arbiter timing
package busPkg;

  // Everything a master drives onto the shared bus
  typedef struct packed {
    logic        beginTransaction;
    logic        readNotWrite;
    logic [31:0] address;
    logic [31:0] writeData;
    logic [3:0]  byteEnables;
  } busRequest_t;

  // Everything a slave or the arbiter drives back
  typedef struct packed {
    logic        endTransaction;
    logic        dataValid;
    logic        busError;
    logic [31:0] readData;
  } busResponse_t;

  // On-chip RAM window
  localparam logic [31:0] ramBaseAddress = 32'h00000000;
  localparam int ramWords = 256;
  localparam int ramAddressBits = 8;

  // Cycles from begin until the arbiter gives up on a transaction
  localparam int busTimeoutCycles = 16;

  // Request and grant bit positions, lower index wins
  localparam int masterCount = 2;
  localparam int hostMaster = 0;
  localparam int dmaMaster = 1;

endpackage

// File: source/ciPkg.sv
// Custom-instruction package with request struct, instruction numbers and DMA sub-commands
package ciPkg;

  // One custom-instruction issue from the core
  typedef struct packed {
    logic        start;
    logic [7:0]  ciN;
    logic [31:0] dataA;
    logic [31:0] dataB;
  } ciRequest_t;

  // Instruction numbers
  localparam logic [7:0] ciSwapByte = 8'h01;
  localparam logic [7:0] ciProfile = 8'h0B;
  localparam logic [7:0] ciGray = 8'h0C;
  localparam logic [7:0] ciDma = 8'h0D;

  // DMA sub-commands in dataA[1:0]
  localparam logic [1:0] dmaStatus = 2'd0;
  localparam logic [1:0] dmaSetSource = 2'd1;
  localparam logic [1:0] dmaSetDestination = 2'd2;
  localparam logic [1:0] dmaStart = 2'd3;

  // Cycles the fabric stays in reset after PLL lock
  localparam int resetHoldCycles = 16;

endpackage

// File: source/dmaEngine.sv
// DMA copy engine, a bus master that copies words under custom-instruction control
module dmaEngine (
  input  logic                 s_systemClock,
  input  logic                 reset,
  input  ciPkg::ciRequest_t    ciRequest,
  output logic                 dmaDone,
  output logic [31:0]          dmaResult,
  output logic                 busRequest,
  input  logic                 busGrant,
  output busPkg::busRequest_t  dmaBus,
  input  busPkg::busResponse_t sharedResponse
);

  typedef enum logic [2:0] {
    idleState,
    requestState,
    beginState,
    endWaitState,
    releaseState
  } dmaState_t;

  dmaState_t   state;
  logic        writePhase;
  logic        errorFlag;
  logic [29:0] sourceWord;
  logic [29:0] destinationWord;
  logic [15:0] remainingWords;
  logic [31:0] copyData;
  logic        dmaSelected;
  logic [1:0]  subCommand;

  assign dmaSelected = ciRequest.start && (ciRequest.ciN == ciPkg::ciDma);
  assign subCommand = ciRequest.dataA[1:0];
  assign dmaDone = dmaSelected;
  assign dmaResult = (dmaSelected && subCommand == ciPkg::dmaStatus) ?
                     {state != idleState, errorFlag, 14'd0, remainingWords} : 32'd0;

  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      state <= idleState;
      writePhase <= 1'b0;
      errorFlag <= 1'b0;
      sourceWord <= '0;
      destinationWord <= '0;
      remainingWords <= '0;
    end else begin
      case (state)
        idleState: begin
          if (dmaSelected) begin
            case (subCommand)
              ciPkg::dmaSetSource: sourceWord <= ciRequest.dataB[29:0];
              ciPkg::dmaSetDestination: destinationWord <= ciRequest.dataB[29:0];
              ciPkg::dmaStart: begin
                remainingWords <= ciRequest.dataB[15:0];
                errorFlag <= 1'b0;
                writePhase <= 1'b0;
                if (ciRequest.dataB[15:0] != 16'd0) begin
                  state <= requestState;
                end
              end
              default: ;
            endcase
          end
        end
        requestState: begin
          if (busGrant) begin
            state <= beginState;
          end
        end
        beginState: state <= endWaitState;
        endWaitState: begin
          if (sharedResponse.endTransaction) begin
            state <= releaseState;
            if (sharedResponse.busError) begin
              errorFlag <= 1'b1;
            end else if (!writePhase) begin
              writePhase <= 1'b1;
            end else begin
              writePhase <= 1'b0;
              remainingWords <= remainingWords - 16'd1;
              sourceWord <= sourceWord + 30'd1;
              destinationWord <= destinationWord + 30'd1;
            end
          end
        end
        // Request is low here so the arbiter can release the grant
        releaseState: begin
          if (errorFlag || remainingWords == 16'd0) begin
            state <= idleState;
          end else begin
            state <= requestState;
          end
        end
        default: state <= idleState;
      endcase
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (state == endWaitState && sharedResponse.endTransaction && !writePhase) begin
      copyData <= sharedResponse.readData;
    end
  end

  assign busRequest = (state == requestState) || (state == beginState) ||
                      (state == endWaitState);

  // Fields held from begin until end, zero otherwise
  always_comb begin
    dmaBus = '0;
    if (state == beginState || state == endWaitState) begin
      dmaBus.beginTransaction = (state == beginState);
      dmaBus.readNotWrite = !writePhase;
      dmaBus.address = writePhase ? {destinationWord, 2'b00} : {sourceWord, 2'b00};
      dmaBus.writeData = writePhase ? copyData : 32'd0;
      dmaBus.byteEnables = 4'hF;
    end
  end

endmodule

// File: source/fabricTop.sv
// System fabric top, shared bus with host and DMA masters, RAM slave and custom instructions
module fabricTop (
  input  logic                 s_systemClock,
  input  logic                 s_pllLocked,
  input  ciPkg::ciRequest_t    ciRequest,
  output logic                 ciDone,
  output logic [31:0]          ciResult,
  input  logic                 hostRequestBus,
  output logic                 hostGrant,
  input  busPkg::busRequest_t  hostBus,
  output busPkg::busResponse_t busResponse,
  output logic                 systemReady
);

  logic                           s_reset;
  logic [busPkg::masterCount-1:0] s_busRequests;
  logic [busPkg::masterCount-1:0] s_busGrants;
  logic                           s_busIdle;
  logic                           s_dmaRequest;
  busPkg::busRequest_t            s_dmaBus;
  busPkg::busRequest_t            s_sharedRequest;
  busPkg::busResponse_t           s_ramResponse;
  busPkg::busResponse_t           s_arbiterResponse;
  logic                           s_dmaDone;
  logic                           s_pixelDone;
  logic                           s_profileDone;
  logic [31:0]                    s_dmaResult;
  logic [31:0]                    s_pixelResult;
  logic [31:0]                    s_profileResult;

  resetSequencer resetSequencer_i (.s_systemClock, .s_pllLocked, .reset(s_reset), .systemReady);

  assign s_busRequests[busPkg::hostMaster] = hostRequestBus;
  assign s_busRequests[busPkg::dmaMaster] = s_dmaRequest;
  assign hostGrant = s_busGrants[busPkg::hostMaster];

  // Masters drive zeros when not granted
  assign s_sharedRequest = hostBus | s_dmaBus;
  assign busResponse = s_ramResponse | s_arbiterResponse;

  busArbiter busArbiter_i (
    .s_systemClock, .reset(s_reset), .busRequests(s_busRequests), .busGrants(s_busGrants),
    .sharedRequest(s_sharedRequest), .sharedResponse(s_ramResponse),
    .arbiterResponse(s_arbiterResponse), .busIdle(s_busIdle)
  );

  sharedRam sharedRam_i (
    .s_systemClock, .reset(s_reset), .sharedRequest(s_sharedRequest),
    .ramResponse(s_ramResponse)
  );

  dmaEngine dmaEngine_i (
    .s_systemClock, .reset(s_reset), .ciRequest, .dmaDone(s_dmaDone),
    .dmaResult(s_dmaResult), .busRequest(s_dmaRequest),
    .busGrant(s_busGrants[busPkg::dmaMaster]), .dmaBus(s_dmaBus),
    .sharedResponse(busResponse)
  );

  pixelOps pixelOps_i (.ciRequest, .pixelDone(s_pixelDone), .pixelResult(s_pixelResult));

  profileCounters profileCounters_i (
    .s_systemClock, .reset(s_reset), .ciRequest, .busIdle(s_busIdle),
    .profileDone(s_profileDone), .profileResult(s_profileResult)
  );

  // No instruction completes while the fabric is held in reset
  assign ciDone = !s_reset && (s_dmaDone | s_pixelDone | s_profileDone);
  assign ciResult = s_dmaResult | s_pixelResult | s_profileResult;

endmodule

// File: source/pixelOps.sv
// Pixel custom instructions, byte swap and RGB565 to gray conversion
module pixelOps (
  input  ciPkg::ciRequest_t ciRequest,
  output logic              pixelDone,
  output logic [31:0]       pixelResult
);

  logic        swapSelected;
  logic        graySelected;
  logic [7:0]  red;
  logic [7:0]  green;
  logic [7:0]  blue;
  logic [15:0] weightedSum;

  assign swapSelected = ciRequest.start && (ciRequest.ciN == ciPkg::ciSwapByte);
  assign graySelected = ciRequest.start && (ciRequest.ciN == ciPkg::ciGray);

  // Channels widened to 8 bits
  assign red = {ciRequest.dataA[15:11], 3'b000};
  assign green = {ciRequest.dataA[10:5], 2'b00};
  assign blue = {ciRequest.dataA[4:0], 3'b000};

  // Weights add up to 256, so the sum fits in 16 bits
  assign weightedSum = 16'd54 * red + 16'd183 * green + 16'd19 * blue;

  assign pixelDone = swapSelected || graySelected;

  always_comb begin
    pixelResult = 32'd0;
    if (swapSelected) begin
      pixelResult = {ciRequest.dataA[7:0], ciRequest.dataA[15:8],
                     ciRequest.dataA[23:16], ciRequest.dataA[31:24]};
    end else if (graySelected) begin
      pixelResult = {24'd0, weightedSum[15:8]};
    end
  end

endmodule

// File: source/profileCounters.sv
// Profiling counters for total cycles and bus idle cycles, read through a custom instruction
module profileCounters (
  input  logic              s_systemClock,
  input  logic              reset,
  input  ciPkg::ciRequest_t ciRequest,
  input  logic              busIdle,
  output logic              profileDone,
  output logic [31:0]       profileResult
);

  logic        profileSelected;
  logic        counting;
  logic [31:0] cycleCount;
  logic [31:0] idleCount;

  assign profileSelected = ciRequest.start && (ciRequest.ciN == ciPkg::ciProfile);
  assign profileDone = profileSelected;

  always_comb begin
    profileResult = 32'd0;
    if (profileSelected) begin
      profileResult = ciRequest.dataA[0] ? idleCount : cycleCount;
    end
  end

  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      counting <= 1'b0;
      cycleCount <= 32'd0;
      idleCount <= 32'd0;
    end else begin
      // Disable wins over enable
      if (profileSelected && ciRequest.dataB[2]) begin
        counting <= 1'b0;
      end else if (profileSelected && ciRequest.dataB[1]) begin
        counting <= 1'b1;
      end
      if (profileSelected && ciRequest.dataB[0]) begin
        cycleCount <= 32'd0;
        idleCount <= 32'd0;
      end else if (counting) begin
        cycleCount <= cycleCount + 32'd1;
        if (busIdle) begin
          idleCount <= idleCount + 32'd1;
        end
      end
    end
  end

endmodule

// File: source/resetSequencer.sv
// Reset sequencer, holds the fabric in reset for a fixed count after PLL lock
module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic reset,
  output logic systemReady
);

  logic [4:0] holdCount;

  // Saturates at the hold count, cleared on loss of lock
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      holdCount <= 5'd0;
    end else if (holdCount != 5'(ciPkg::resetHoldCycles)) begin
      holdCount <= holdCount + 5'd1;
    end
  end

  assign systemReady = (holdCount == 5'(ciPkg::resetHoldCycles));
  assign reset = !systemReady;

endmodule

// File: source/sharedRam.sv
// On-chip RAM slave on the shared bus, word wide with byte enables
module sharedRam (
  input  logic                 s_systemClock,
  input  logic                 reset,
  input  busPkg::busRequest_t  sharedRequest,
  output busPkg::busResponse_t ramResponse
);

  logic [31:0]                       memory [0:busPkg::ramWords-1];
  logic [busPkg::ramAddressBits-1:0] wordIndex;
  logic                              addressHit;
  logic                              accessStart;
  logic                              responding;
  logic                              readPending;
  logic [31:0]                       readWord;

  assign wordIndex = sharedRequest.address[busPkg::ramAddressBits+1:2];
  assign addressHit = (sharedRequest.address[31:busPkg::ramAddressBits+2] ==
                       busPkg::ramBaseAddress[31:busPkg::ramAddressBits+2]);
  assign accessStart = sharedRequest.beginTransaction && addressHit;

  always_ff @(posedge s_systemClock) begin
    if (accessStart) begin
      if (!sharedRequest.readNotWrite) begin
        for (int byteLane = 0; byteLane < 4; byteLane++) begin
          if (sharedRequest.byteEnables[byteLane]) begin
            memory[wordIndex][8*byteLane +: 8] <= sharedRequest.writeData[8*byteLane +: 8];
          end
        end
      end
      readWord <= memory[wordIndex];
    end
  end

  // Answer one cycle after begin
  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      responding <= 1'b0;
      readPending <= 1'b0;
    end else begin
      responding <= accessStart;
      readPending <= accessStart && sharedRequest.readNotWrite;
    end
  end

  assign ramResponse = '{
    endTransaction: responding,
    dataValid: readPending,
    busError: 1'b0,
    readData: readPending ? readWord : 32'd0
  };

endmodule

// File: testbench/busArbiter_sva.sv
// Bus protocol assertions on grants, errors and transaction completion at the arbiter
module busArbiter_sva (
  input logic                           s_systemClock,
  input logic                           reset,
  input logic [busPkg::masterCount-1:0] busGrants,
  input busPkg::busRequest_t            sharedRequest,
  input busPkg::busResponse_t           sharedResponse,
  input busPkg::busResponse_t           arbiterResponse
);
  timeunit 1ns;
  timeprecision 100ps;

  int   assertionFailures = 0;
  logic anyEnd;
  logic anyError;

  // Same OR as the shared response at the top
  assign anyEnd = sharedResponse.endTransaction || arbiterResponse.endTransaction;
  assign anyError = sharedResponse.busError || arbiterResponse.busError;

  grantsOneHot: assert property (@(posedge s_systemClock) $onehot0(busGrants))
    else begin
      assertionFailures++;
      $error("More than one bus grant is active");
    end

  errorWithEnd: assert property (@(posedge s_systemClock) disable iff (reset)
                                 anyError |-> anyEnd)
    else begin
      assertionFailures++;
      $error("busError seen without endTransaction");
    end

  noGrantInReset: assert property (@(posedge s_systemClock) reset |-> busGrants == '0)
    else begin
      assertionFailures++;
      $error("A bus grant is active during reset");
    end

  beginEnds: assert property (@(posedge s_systemClock) disable iff (reset)
                              sharedRequest.beginTransaction |->
                              ##[1:busPkg::busTimeoutCycles] anyEnd)
    else begin
      assertionFailures++;
      $error("Transaction did not end within the bus timeout");
    end

endmodule

bind busArbiter busArbiter_sva arbiterChecks (.*);

// File: testbench/fabricTb.sv
// Testbench for the system fabric, drives host bus and custom instructions and checks responses
module fabricTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clockPeriod = 8;
  localparam int resetCycles = 10;
  localparam int expectedCycles = 1500;
  // Margin of three times the expected run length
  localparam int cycleLimit = 3 * expectedCycles + 500;
  localparam int testWords = 16;
  localparam int dmaWords = 8;
  localparam int dmaSourceWord = 64;
  localparam int dmaDestinationWord = 128;
  localparam int profileWindow = 20;

  logic                 s_systemClock;
  logic                 s_pllLocked;
  ciPkg::ciRequest_t    ciRequest;
  logic                 ciDone;
  logic [31:0]          ciResult;
  logic                 hostRequestBus;
  logic                 hostGrant;
  busPkg::busRequest_t  hostBus;
  busPkg::busResponse_t busResponse;
  logic                 systemReady;

  integer      seed;
  int          cycleCount;
  logic [31:0] ramModel [0:busPkg::ramWords-1];

  fabricTop fabricTop_i (.*);

  initial begin
    s_systemClock = 1'b0;
    forever #(clockPeriod / 2) s_systemClock = ~s_systemClock;
  end

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped after a failure");
  endtask

  task automatic checkValue(input string signalName, input logic [31:0] actual,
                            input logic [31:0] expected);
    assert (actual === expected) else
      stopWithFailure($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h",
                                signalName, actual, expected));
  endtask

  // Watchdog and arbiter assertion monitor
  initial cycleCount = 0;
  always @(negedge s_systemClock) begin
    cycleCount++;
    if (fabricTop_i.busArbiter_i.arbiterChecks.assertionFailures != 0) begin
      stopWithFailure("A bus protocol assertion on the arbiter failed");
    end
    if (cycleCount >= cycleLimit) begin
      stopWithFailure($sformatf("Timeout, the run did not finish within %0d cycles",
                                cycleLimit));
    end
  end

  function automatic logic [31:0] swapExpected(input logic [31:0] word);
    logic [31:0] swapped;
    int lane;
    for (lane = 0; lane < 4; lane++) begin
      swapped[8*lane +: 8] = word[8*(3-lane) +: 8];
    end
    return swapped;
  endfunction

  function automatic logic [31:0] grayExpected(input logic [15:0] pixel);
    int red8;
    int green8;
    int blue8;
    red8 = pixel[15:11] * 8;
    green8 = pixel[10:5] * 4;
    blue8 = pixel[4:0] * 8;
    return (54 * red8 + 183 * green8 + 19 * blue8) / 256;
  endfunction

  task automatic issueCi(input logic [7:0] number, input logic [31:0] dataA,
                         input logic [31:0] dataB, output logic [31:0] result);
    @(posedge s_systemClock);
    #1;
    ciRequest = '{start: 1'b1, ciN: number, dataA: dataA, dataB: dataB};
    @(negedge s_systemClock);
    checkValue("ciDone", ciDone, 1);
    result = ciResult;
    @(posedge s_systemClock);
    #1;
    ciRequest = '0;
  endtask

  // One host transaction, latency counts cycles from begin to end
  task automatic hostAccess(input logic isRead, input logic [31:0] address,
                            input logic [31:0] writeData, input logic [3:0] byteEnables,
                            output busPkg::busResponse_t response, output int latency);
    @(posedge s_systemClock);
    #1;
    hostRequestBus = 1'b1;
    do begin
      @(negedge s_systemClock);
    end while (!hostGrant);
    @(posedge s_systemClock);
    #1;
    hostBus = '{beginTransaction: 1'b1, readNotWrite: isRead, address: address,
                writeData: writeData, byteEnables: byteEnables};
    latency = 0;
    forever begin
      @(negedge s_systemClock);
      if (busResponse.endTransaction) begin
        break;
      end
      @(posedge s_systemClock);
      #1;
      hostBus.beginTransaction = 1'b0;
      latency++;
    end
    response = busResponse;
    @(posedge s_systemClock);
    #1;
    hostRequestBus = 1'b0;
    hostBus = '0;
  endtask

  task automatic writeWord(input int wordIndex, input logic [31:0] data,
                           input logic [3:0] byteEnables);
    busPkg::busResponse_t response;
    int latency;
    int lane;
    hostAccess(1'b0, wordIndex * 4, data, byteEnables, response, latency);
    checkValue("write latency", latency, 1);
    checkValue("write busError", response.busError, 0);
    for (lane = 0; lane < 4; lane++) begin
      if (byteEnables[lane]) begin
        ramModel[wordIndex][8*lane +: 8] = data[8*lane +: 8];
      end
    end
  endtask

  task automatic readCheck(input int wordIndex);
    busPkg::busResponse_t response;
    int latency;
    hostAccess(1'b1, wordIndex * 4, 32'd0, 4'hF, response, latency);
    checkValue("read latency", latency, 1);
    checkValue("read dataValid", response.dataValid, 1);
    checkValue($sformatf("readData of word %0d", wordIndex), response.readData,
               ramModel[wordIndex]);
  endtask

  initial begin
    logic [31:0]          randomWord;
    logic [31:0]          result;
    logic [3:0]           byteEnables;
    busPkg::busResponse_t response;
    int                   latency;
    int                   index;
    seed = 32'h418e;
    s_pllLocked = 1'b0;
    ciRequest = '0;
    hostRequestBus = 1'b0;
    hostBus = '0;
    repeat (resetCycles) @(posedge s_systemClock);
    #1;
    s_pllLocked = 1'b1;
    // Pending request must not be granted before release
    hostRequestBus = 1'b1;
    // An instruction issued in reset must not complete
    ciRequest = '{start: 1'b1, ciN: ciPkg::ciSwapByte, dataA: 32'h0123_4567, dataB: 32'd0};
    for (index = 0; index < ciPkg::resetHoldCycles; index++) begin
      @(negedge s_systemClock);
      checkValue("systemReady", systemReady, 0);
      checkValue("hostGrant", hostGrant, 0);
      checkValue("ciDone", ciDone, 0);
    end
    @(negedge s_systemClock);
    checkValue("systemReady", systemReady, 1);
    @(posedge s_systemClock);
    #1;
    hostRequestBus = 1'b0;
    ciRequest = '0;

    for (index = 0; index < testWords; index++) begin
      randomWord = $random(seed);
      issueCi(ciPkg::ciSwapByte, randomWord, 32'd0, result);
      checkValue("swapped word", result, swapExpected(randomWord));
      randomWord = $random(seed);
      issueCi(ciPkg::ciGray, {16'd0, randomWord[15:0]}, 32'd0, result);
      checkValue("gray level", result, grayExpected(randomWord[15:0]));
    end

    // Full words first so every byte of the model is known
    for (index = 0; index < testWords; index++) begin
      randomWord = $random(seed);
      writeWord(index, randomWord, 4'hF);
    end
    for (index = 0; index < testWords; index++) begin
      randomWord = $random(seed);
      byteEnables = $random(seed);
      writeWord(index, randomWord, byteEnables);
    end
    for (index = 0; index < testWords; index++) begin
      readCheck(index);
    end

    // Unmapped address, only the arbiter answers
    hostAccess(1'b1, 32'h0000_1000, 32'd0, 4'hF, response, latency);
    checkValue("timeout latency", latency, busPkg::busTimeoutCycles);
    checkValue("timeout busError", response.busError, 1);
    checkValue("timeout dataValid", response.dataValid, 0);

    for (index = 0; index < dmaWords; index++) begin
      randomWord = $random(seed);
      writeWord(dmaSourceWord + index, randomWord, 4'hF);
    end
    issueCi(ciPkg::ciDma, {30'd0, ciPkg::dmaSetSource}, dmaSourceWord, result);
    issueCi(ciPkg::ciDma, {30'd0, ciPkg::dmaSetDestination}, dmaDestinationWord, result);
    issueCi(ciPkg::ciDma, {30'd0, ciPkg::dmaStart}, dmaWords, result);
    index = 0;
    do begin
      readCheck(index % testWords);
      index++;
      issueCi(ciPkg::ciDma, {30'd0, ciPkg::dmaStatus}, 32'd0, result);
    end while (result[31]);
    checkValue("DMA error flag", result[30], 0);
    checkValue("DMA remaining words", result[15:0], 0);
    for (index = 0; index < dmaWords; index++) begin
      ramModel[dmaDestinationWord + index] = ramModel[dmaSourceWord + index];
      readCheck(dmaDestinationWord + index);
    end

    // Clear and enable, then disable in the last counted cycle
    issueCi(ciPkg::ciProfile, 32'd0, 32'h3, result);
    repeat (profileWindow - 2) @(posedge s_systemClock);
    issueCi(ciPkg::ciProfile, 32'd0, 32'h4, result);
    issueCi(ciPkg::ciProfile, 32'd0, 32'h0, result);
    checkValue("profile cycle counter", result, profileWindow);
    issueCi(ciPkg::ciProfile, 32'd1, 32'h0, result);
    checkValue("profile idle counter", result, profileWindow);

    if (fabricTop_i.busArbiter_i.arbiterChecks.assertionFailures == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      stopWithFailure("A bus protocol assertion on the arbiter failed");
    end
  end

endmodule
